// File: Bender.yml
package:
  name: ddr_dq_egress

sources:
  # RTL in compile order
  - ddr_dq_pkg.sv
  - dq_delay_line.sv
  - dbi_lane_encoder.sv
  - dq_egress_pack.sv
  - ddr_dq_egress.sv

  # Testbench
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_ddr_dq_egress.sv

// File: all.f
+incdir+.
ddr_dq_pkg.sv
dq_delay_line.sv
dbi_lane_encoder.sv
dq_egress_pack.sv
ddr_dq_egress.sv
tb_ddr_dq_egress.sv

// File: dbi_lane_encoder.sv
/* Egress DBI for one phase of one byte: inverts unmasked lanes when the counted level
   exceeds half of the unmasked lanes. One cycle of latency, decision registered with data. */

`timescale 1ns/1ps

module dbi_lane_encoder
   import ddr_dq_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_rst,
   input  logic     i_dbi_en,     // Enable inversion decision
   input  logic     i_dbi_ones,   // 1 counts ones, 0 counts zeros
   input  dq_lane_t i_dbi_mask,   // Set bit excludes that lane
   input  dq_lane_t i_lane,
   output dq_lane_t o_lane,
   output logic     o_dbi
);

   dq_lane_t unmasked;
   dq_lane_t counted;
   dbi_cnt_t count;
   dbi_cnt_t count_msk;
   logic     dbi_d;
   dq_lane_t lane_d;

   // ------------------------------
   // Count selection
   // ------------------------------

   assign unmasked = ~i_dbi_mask;

   // Pick ones or zeros, then drop masked lanes
   assign counted = unmasked & (i_dbi_ones ? i_lane : ~i_lane);

   // Level count over unmasked lanes
   always_comb begin
      integer i;
      count = '0;
      for (i = 0; i < DQ_WIDTH; i++) begin
         count = count + dbi_cnt_t'(counted[i]);
      end
   end

   // Number of lanes taking part
   always_comb begin
      integer j;
      count_msk = '0;
      for (j = 0; j < DQ_WIDTH; j++) begin
         count_msk = count_msk + dbi_cnt_t'(unmasked[j]);
      end
   end

   // ------------------------------
   // Decision and inversion
   // ------------------------------

   // Strictly more than half, rounded down
   assign dbi_d = i_dbi_en & (count > (count_msk >> 1));

   // Masked lanes pass through untouched
   assign lane_d = ({DQ_WIDTH{dbi_d}} & unmasked) ^ i_lane;

   // ------------------------------
   // Output register
   // ------------------------------

   always_ff @(posedge i_clk, posedge i_rst) begin
      if (i_rst) begin
         o_lane <= '0;
         o_dbi  <= 1'b0;
      end else begin
         o_lane <= lane_d;
         o_dbi  <= dbi_d;     // Flag stays aligned with its data
      end
   end

endmodule

// File: ddr_dq_egress.sv
/* Egress data path of one DQ byte lane: reorder and delay, per-phase DBI, repack.
   Latency is i_delay + 2 cycles; every cycle carries a word, no handshake. */

`timescale 1ns/1ps

module ddr_dq_egress
   import ddr_dq_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_rst,
   input  dq_word_t i_wop_data,
   input  dly_sel_t i_delay,
   input  logic     i_dbi_en,
   input  logic     i_dbi_ones,
   input  dq_lane_t i_dbi_mask,
   input  logic     i_dbi_clr,
   output dq_word_t o_wop_data,
   output dbi_t     o_dbi,
   output logic     o_dbi_seen
);

   dq_word_t dly_pow;    // Delayed word, phases-of-words
   dq_word_t enc_pow;    // Encoded word, phases-of-words
   dbi_t     enc_dbi;

   // ------------------------------
   // Input side
   // ------------------------------

   dq_delay_line u_delay_line (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_wop_data (i_wop_data),
      .i_delay    (i_delay),
      .o_pow_data (dly_pow)
   );

   // ------------------------------
   // One DBI encoder per phase
   // ------------------------------

   genvar ph;
   generate
      for (ph = 0; ph < NUM_PH; ph++) begin : g_dbi
         dbi_lane_encoder u_dbi_enc (
            .i_clk      (i_clk),
            .i_rst      (i_rst),
            .i_dbi_en   (i_dbi_en),
            .i_dbi_ones (i_dbi_ones),
            .i_dbi_mask (i_dbi_mask),
            .i_lane     (dly_pow[ph*DQ_WIDTH +: DQ_WIDTH]),
            .o_lane     (enc_pow[ph*DQ_WIDTH +: DQ_WIDTH]),
            .o_dbi      (enc_dbi[ph])
         );
      end
   endgenerate

   // ------------------------------
   // Output side
   // ------------------------------

   dq_egress_pack u_egress_pack (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_dbi_clr  (i_dbi_clr),
      .i_pow_data (enc_pow),
      .i_dbi      (enc_dbi),
      .o_wop_data (o_wop_data),
      .o_dbi      (o_dbi),
      .o_dbi_seen (o_dbi_seen)
   );

endmodule

// File: ddr_dq_pkg.sv
/* Shared widths and vector types for one DQ byte lane with 4 data phases per core word.
   Delay select covers 0 to MAX_DLY cycles and must only change while the stream is idle. */

package ddr_dq_pkg;

   // ------------------------------
   // Lane and word geometry
   // ------------------------------

   localparam int DQ_WIDTH = 8;                  // Lanes in one byte
   localparam int NUM_PH   = 4;                  // Data phases per core word
   localparam int WORD_W   = DQ_WIDTH * NUM_PH;  // Full core word

   // Ones counter needs to hold DQ_WIDTH itself
   localparam int CNT_W    = $clog2(DQ_WIDTH) + 1;

   // ------------------------------
   // Delay select
   // ------------------------------

   localparam int DLY_W    = 2;
   localparam int MAX_DLY  = 3;                  // Largest delay in cycles

   // ------------------------------
   // Vector types
   // ------------------------------

   // One phase of byte data, also used for the DBI mask
   typedef logic [DQ_WIDTH-1:0] dq_lane_t;

   // Full word, words-of-phases or phases-of-words order
   typedef logic [WORD_W-1:0]   dq_word_t;

   // One DBI flag per phase
   typedef logic [NUM_PH-1:0]   dbi_t;

   // Delay in cycles
   typedef logic [DLY_W-1:0]    dly_sel_t;

   // Ones or zeros count over one lane vector
   typedef logic [CNT_W-1:0]    dbi_cnt_t;

endpackage

// File: dq_delay_line.sv
/* Reorders words-of-phases into phases-of-words and delays by 0 to MAX_DLY cycles.
   A delay of 0 is a pure combinational path; i_delay is quasi-static. */

`timescale 1ns/1ps

module dq_delay_line
   import ddr_dq_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_rst,
   input  dq_word_t i_wop_data,   // Words-of-phases order
   input  dly_sel_t i_delay,      // Cycles of delay
   output dq_word_t o_pow_data    // Phases-of-words order
);

   dq_word_t pow_word;
   dq_word_t dly_q [1:MAX_DLY];

   // ------------------------------
   // Reorder WOP to POW
   // ------------------------------

   // Bit (lane*NUM_PH + ph) moves to bit (ph*DQ_WIDTH + lane)
   always_comb begin
      integer lane;
      integer ph;
      pow_word = '0;
      for (ph = 0; ph < NUM_PH; ph++) begin
         for (lane = 0; lane < DQ_WIDTH; lane++) begin
            pow_word[(ph*DQ_WIDTH)+lane] = i_wop_data[(lane*NUM_PH)+ph];
         end
      end
   end

   // ------------------------------
   // Delay stages
   // ------------------------------

   // Shift on every clock, no enable
   always_ff @(posedge i_clk, posedge i_rst) begin
      integer k;
      if (i_rst) begin
         for (k = 1; k <= MAX_DLY; k++) begin
            dly_q[k] <= '0;
         end
      end else begin
         dly_q[1] <= pow_word;
         for (k = 2; k <= MAX_DLY; k++) begin
            dly_q[k] <= dly_q[k-1];
         end
      end
   end

   // ------------------------------
   // Tap select
   // ------------------------------

   always_comb begin
      integer k;
      o_pow_data = pow_word;            // Delay 0 bypasses all stages
      for (k = 1; k <= MAX_DLY; k++) begin
         if (i_delay == dly_sel_t'(k)) begin
            o_pow_data = dly_q[k];
         end
      end
   end

endmodule

// File: dq_egress_pack.sv
/* Registers the encoded word back in words-of-phases order plus the DBI flags.
   Sticky flag is single-clock; a high i_dbi_clr wins over a new inversion. */

`timescale 1ns/1ps

module dq_egress_pack
   import ddr_dq_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_rst,
   input  logic     i_dbi_clr,    // Level clear of the sticky flag
   input  dq_word_t i_pow_data,   // Phases-of-words order
   input  dbi_t     i_dbi,
   output dq_word_t o_wop_data,   // Words-of-phases order
   output dbi_t     o_dbi,
   output logic     o_dbi_seen    // Any inversion since last clear
);

   dq_word_t wop_word;
   logic     any_dbi;

   // ------------------------------
   // Reorder POW to WOP
   // ------------------------------

   always_comb begin
      integer lane;
      integer ph;
      wop_word = '0;
      for (lane = 0; lane < DQ_WIDTH; lane++) begin
         for (ph = 0; ph < NUM_PH; ph++) begin
            wop_word[(lane*NUM_PH)+ph] = i_pow_data[(ph*DQ_WIDTH)+lane];
         end
      end
   end

   // ------------------------------
   // Output registers
   // ------------------------------

   always_ff @(posedge i_clk, posedge i_rst) begin
      if (i_rst) begin
         o_wop_data <= '0;
         o_dbi      <= '0;
      end else begin
         o_wop_data <= wop_word;
         o_dbi      <= i_dbi;
      end
   end

   // Looks at the flags entering o_dbi so both update on one edge
   assign any_dbi = |i_dbi;

   // ------------------------------
   // Sticky inversion flag
   // ------------------------------

   always_ff @(posedge i_clk, posedge i_rst) begin
      if (i_rst) begin
         o_dbi_seen <= 1'b0;
      end else if (i_dbi_clr) begin
         o_dbi_seen <= 1'b0;          // Clear has priority
      end else if (any_dbi) begin
         o_dbi_seen <= 1'b1;
      end
   end

endmodule

// File: tb_dq_ref.svh
/* Reference rules for the DQ egress testbench: bit ordering, per-phase DBI and the LFSR.
   Included inside the testbench module after ddr_dq_pkg is imported. */

`ifndef TB_DQ_REF_SVH
`define TB_DQ_REF_SVH

// 16-bit Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
   logic fb;
   fb = s[15] ^ s[13] ^ s[12] ^ s[10];
   return {s[14:0], fb};
endfunction

// Pick one phase out of a words-of-phases word
function automatic dq_lane_t phase_of(input dq_word_t w, input int ph);
   dq_lane_t v;
   int       lane;
   for (lane = 0; lane < DQ_WIDTH; lane++) begin
      v[lane] = w[lane*NUM_PH + ph];
   end
   return v;
endfunction

// Unmasked lanes flip when the counted level is over half of them
function automatic dq_lane_t dbi_ref(input dq_lane_t lane, input logic en, input logic ones,
                                     input dq_lane_t mask, output logic inv);
   int used;
   int level;
   int i;
   used  = 0;
   level = 0;
   for (i = 0; i < DQ_WIDTH; i++) begin
      if (!mask[i]) begin
         used++;
         if (lane[i] == ones) begin
            level++;
         end
      end
   end
   inv = en && (level > used / 2);
   return inv ? (lane ^ ~mask) : lane;
endfunction

// Expected output word in words-of-phases order, flags per phase
function automatic dq_word_t expect_word(input dq_word_t w, input logic en, input logic ones,
                                         input dq_lane_t mask, output dbi_t flags);
   dq_word_t r;
   dq_lane_t enc;
   logic     inv;
   int       ph;
   int       lane;
   r = w;
   for (ph = 0; ph < NUM_PH; ph++) begin
      enc       = dbi_ref(phase_of(w, ph), en, ones, mask, inv);
      flags[ph] = inv;
      for (lane = 0; lane < DQ_WIDTH; lane++) begin
         r[lane*NUM_PH + ph] = enc[lane];
      end
   end
   return r;
endfunction

`endif

// File: tb_ddr_dq_egress.sv
/* Testbench for the DQ egress path. Controls change only in reconfigure, with no tracked
   word in flight; each tracked word is due delay + 2 edges after the edge that drives it. */

`timescale 1ns/1ps

module tb_ddr_dq_egress
   import ddr_dq_pkg::*;
();

   localparam int DRAIN_LIMIT = 32;
   localparam int GAP_CYCLES  = MAX_DLY + 4;

   logic     clk;
   logic     rst;
   dq_word_t wop_in;
   dly_sel_t delay;
   logic     dbi_en;
   logic     dbi_ones;
   dq_lane_t dbi_mask;
   logic     dbi_clr;
   dq_word_t wop_out;
   dbi_t     dbi_out;
   logic     dbi_seen;

   // Expected-output queue and checker state
   int       q_due[$];
   dq_word_t q_wop[$];
   dbi_t     q_dbi[$];
   int       edge_cnt = 0;
   logic     clr_q    = 1'b0;
   logic     track    = 1'b0;
   logic     chk_en   = 1'b0;
   logic     zero_chk = 1'b0;
   dq_word_t exp_wop  = '0;
   dbi_t     exp_dbi  = '0;
   logic     exp_seen = 1'b0;

   // Mirror of the controls applied to the DUT
   dly_sel_t cfg_dly  = '0;
   logic     cfg_en   = 1'b0;
   logic     cfg_ones = 1'b1;
   dq_lane_t cfg_mask = '0;

   int          err_cnt     = 0;
   int          timeout_cnt = 0;
   int          n_checks    = 0;
   int          n_tests     = 0;
   int          n_tests_bad = 0;
   int          err_mark    = 0;
   int          chk_mark    = 0;
   string       cur_test    = "none";
   logic [15:0] lfsr_state  = 16'd5910;

   `include "tb_dq_ref.svh"

   ddr_dq_egress DUT (
      .i_clk      (clk),
      .i_rst      (rst),
      .i_wop_data (wop_in),
      .i_delay    (delay),
      .i_dbi_en   (dbi_en),
      .i_dbi_ones (dbi_ones),
      .i_dbi_mask (dbi_mask),
      .i_dbi_clr  (dbi_clr),
      .o_wop_data (wop_out),
      .o_dbi      (dbi_out),
      .o_dbi_seen (dbi_seen)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   // ------------------------------
   // Checker
   // ------------------------------

   always @(posedge clk) begin
      edge_cnt <= edge_cnt + 1;
      clr_q    <= dbi_clr;            // Clear level seen by the sticky flag
   end

   // Loads the entry due at this edge for the next rising edge to compare
   always @(negedge clk) begin
      chk_en = 1'b0;
      while (q_due.size() > 0 && q_due[0] < edge_cnt) begin
         err_cnt++;
         $display("[%s] word due at edge %0d was never compared", cur_test, q_due[0]);
         void'(q_due.pop_front());
         void'(q_wop.pop_front());
         void'(q_dbi.pop_front());
      end
      if (q_due.size() > 0 && q_due[0] == edge_cnt) begin
         void'(q_due.pop_front());
         exp_wop  = q_wop.pop_front();
         exp_dbi  = q_dbi.pop_front();
         exp_seen = clr_q ? 1'b0 : (exp_seen | (|exp_dbi));
         chk_en   = 1'b1;
         n_checks++;
      end
      if (zero_chk) begin
         n_checks++;
      end
   end

   task automatic report_mismatch(input string sig, input dq_word_t exp, input dq_word_t act);
      err_cnt++;
      $display("** Error [%s] %s expected %h actual %h", cur_test, sig, exp, act);
   endtask

   a_data : assert property (@(posedge clk) chk_en |-> (wop_out == exp_wop))
      else report_mismatch("o_wop_data", exp_wop, $sampled(wop_out));
   a_dbi : assert property (@(posedge clk) chk_en |-> (dbi_out == exp_dbi))
      else report_mismatch("o_dbi", dq_word_t'(exp_dbi), dq_word_t'($sampled(dbi_out)));
   a_seen : assert property (@(posedge clk) chk_en |-> (dbi_seen == exp_seen))
      else report_mismatch("o_dbi_seen", dq_word_t'(exp_seen), dq_word_t'($sampled(dbi_seen)));

   // Quiet outputs around reset
   a_zero_data : assert property (@(posedge clk) zero_chk |-> (wop_out == '0))
      else report_mismatch("o_wop_data", '0, $sampled(wop_out));
   a_zero_dbi : assert property (@(posedge clk) zero_chk |-> (dbi_out == '0))
      else report_mismatch("o_dbi", '0, dq_word_t'($sampled(dbi_out)));
   a_zero_seen : assert property (@(posedge clk) zero_chk |-> !dbi_seen)
      else report_mismatch("o_dbi_seen", '0, dq_word_t'($sampled(dbi_seen)));

   // ------------------------------
   // Stimulus helpers
   // ------------------------------

   function automatic dq_word_t next_rand_word();
      dq_word_t w;
      int       i;
      for (i = 0; i < WORD_W; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         w[i]       = lfsr_state[0];
      end
      return w;
   endfunction

   // Never inverts under the current controls
   function automatic dq_word_t idle_word();
      return (cfg_en && !cfg_ones) ? {WORD_W{1'b1}} : {WORD_W{1'b0}};
   endfunction

   task automatic drive_word(input dq_word_t w, input logic clr);
      dq_word_t exp;
      dbi_t     flags;
      @(posedge clk);
      wop_in  <= w;
      dbi_clr <= clr;
      if (track) begin
         exp = expect_word(w, cfg_en, cfg_ones, cfg_mask, flags);
         q_due.push_back(edge_cnt + int'(cfg_dly) + 3);   // Out d+2 edges after this one
         q_wop.push_back(exp);
         q_dbi.push_back(flags);
      end
   endtask

   task automatic drain();
      int n;
      track = 1'b0;
      n     = 0;
      while (q_due.size() > 0 && n < DRAIN_LIMIT) begin
         drive_word(idle_word(), 1'b0);
         n++;
      end
      if (q_due.size() > 0) begin
         timeout_cnt++;
         $display("[%s] timeout with %0d expected words still pending", cur_test, q_due.size());
         q_due.delete();
         q_wop.delete();
         q_dbi.delete();
      end
      @(negedge clk);                 // Last compare has finished
   endtask

   task automatic reconfigure(input dly_sel_t d, input logic en, input logic ones,
                              input dq_lane_t mask);
      int n;
      drain();
      cfg_dly  = d;
      cfg_en   = en;
      cfg_ones = ones;
      cfg_mask = mask;
      @(posedge clk);
      delay    <= d;
      dbi_en   <= en;
      dbi_ones <= ones;
      dbi_mask <= mask;
      wop_in   <= idle_word();
      dbi_clr  <= 1'b1;
      // Clear held until old words have left the pipe
      for (n = 1; n < GAP_CYCLES; n++) begin
         drive_word(idle_word(), 1'b1);
      end
      exp_seen = 1'b0;
      track    = 1'b1;
   endtask

   task automatic begin_test(input string name);
      cur_test = name;
      err_mark = err_cnt + timeout_cnt;
      chk_mark = n_checks;
   endtask

   task automatic end_test();
      int bad;
      bad = err_cnt + timeout_cnt - err_mark;
      n_tests++;
      if (bad == 0) begin
         $display("test %-16s ok, %0d checks", cur_test, n_checks - chk_mark);
      end else begin
         n_tests_bad++;
         $display("test %-16s bad, %0d errors", cur_test, bad);
      end
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------

   initial begin
      int n;
      int d;
      rst      = 1'b1;
      wop_in   = '0;
      delay    = '0;
      dbi_en   = 1'b0;
      dbi_ones = 1'b1;
      dbi_mask = '0;
      dbi_clr  = 1'b0;

      begin_test("reset_state");
      @(posedge clk);
      zero_chk = 1'b1;
      for (n = 1; n < 4; n++) begin
         @(posedge clk);
      end
      rst <= 1'b0;
      for (n = 0; n < 8; n++) begin
         drive_word('0, 1'b0);
      end
      zero_chk = 1'b0;
      @(negedge clk);
      end_test();

      begin_test("transparent");
      reconfigure(2'd0, 1'b0, 1'b1, 8'h00);
      for (n = 0; n < 40; n++) begin
         drive_word(next_rand_word(), 1'b0);
      end
      drain();
      end_test();

      begin_test("delay_select");
      for (d = 0; d <= MAX_DLY; d++) begin
         reconfigure(dly_sel_t'(d), 1'b0, 1'b1, 8'h00);
         drive_word(32'hC35A_A5F0 + dq_word_t'(d), 1'b0);   // Marker
         for (n = 0; n < 6; n++) begin
            drive_word(next_rand_word(), 1'b0);
         end
         drain();
      end
      end_test();

      begin_test("dbi_ones");
      reconfigure(2'd1, 1'b1, 1'b1, 8'h00);
      for (n = 0; n < 64; n++) begin
         drive_word(next_rand_word(), 1'b0);
      end
      drain();
      end_test();

      begin_test("dbi_zeros_mask");
      reconfigure(2'd2, 1'b1, 1'b0, 8'h24);
      for (n = 0; n < 40; n++) begin
         drive_word(next_rand_word(), 1'b0);
      end
      reconfigure(2'd3, 1'b1, 1'b0, 8'hE0);   // Five lanes take part
      for (n = 0; n < 40; n++) begin
         drive_word(next_rand_word(), 1'b0);
      end
      drain();
      end_test();

      begin_test("sticky_flag");
      reconfigure(2'd0, 1'b1, 1'b1, 8'h00);
      drive_word('0, 1'b0);
      drive_word('0, 1'b0);
      drive_word(32'h1111_1111, 1'b0);        // Phase 0 all ones
      for (n = 0; n < 4; n++) begin
         drive_word('0, 1'b0);
      end
      drive_word('0, 1'b1);
      drive_word('0, 1'b1);
      drive_word('0, 1'b0);
      drive_word(32'h2222_2222, 1'b0);        // Phase 1 all ones
      drive_word('0, 1'b1);                   // Sampled with that word's flags
      for (n = 0; n < 3; n++) begin
         drive_word('0, 1'b0);
      end
      drain();
      end_test();

      $display("tests %0d, bad %0d, checks %0d, errors %0d, timeouts %0d",
               n_tests, n_tests_bad, n_checks, err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0 && n_tests_bad == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule
